// File: flist.f
hw/rms_norm_pkg.sv
hw/matrix_fifo.sv
hw/square_reduce.sv
hw/square_accumulator.sv
hw/inv_sqrt_unit.sv
hw/repeat_buffer.sv
hw/norm_scale.sv
hw/rms_norm_2d.sv
verification/rms_norm_2d_tb.sv

// File: hw/inv_sqrt_unit.sv
// Sequential inverse square root of the mean square, an integer root then a reciprocal
`timescale 1ns/100ps
`default_nettype none

module inv_sqrt_unit #(
    parameter int total_dim0 = 4,
    parameter int total_dim1 = 4,
    parameter int compute_dim0 = 2,
    parameter int compute_dim1 = 2,
    parameter int channels = 2,
    localparam int lanes = compute_dim0 * compute_dim1,
    localparam int num_iters = (total_dim0 / compute_dim0) * (total_dim1 / compute_dim1)
        * channels,
    localparam int acc_width = rms_norm_pkg::square_width + $clog2(lanes)
        + $clog2(num_iters),
    localparam int inv_width = rms_norm_pkg::inv_sqrt_width
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [acc_width-1:0] mean_data,
    input  logic                 mean_valid,
    output logic                 mean_ready,
    output logic [inv_width-1:0] inv_data,
    output logic                 inv_valid,
    input  logic                 inv_ready
);
    localparam int root_width = (acc_width + 1) / 2;
    localparam int rem_width = root_width + 2;
    localparam int step_width = $clog2(root_width + inv_width);
    localparam logic [1:0] s_idle = 2'd0;
    localparam logic [1:0] s_sqrt = 2'd1;
    localparam logic [1:0] s_div = 2'd2;
    // One in the combined scale and root fraction format
    localparam logic [inv_width-1:0] numerator = inv_width'(1)
        << (rms_norm_pkg::inv_sqrt_frac_width + rms_norm_pkg::in_frac_width);

    logic [1:0] state;
    logic [step_width-1:0] step;
    logic [2*root_width-1:0] rad;
    logic [rem_width-1:0] sq_rem;
    logic [root_width-1:0] root;
    logic [root_width+3:0] sq_shift;
    logic [root_width+3:0] sq_trial;
    logic [root_width+3:0] sq_diff;
    logic sq_fit;
    logic [root_width-1:0] div_rem;
    logic [root_width:0] div_shift;
    logic [root_width:0] div_diff;
    logic div_fit;
    logic [inv_width-1:0] quot;
    logic [inv_width-1:0] quot_next;

    assign mean_ready = (state == s_idle) && !inv_valid;

    // Restoring root, two radicand bits per step
    always_comb begin
        sq_shift = {sq_rem, rad[2*root_width-1 -: 2]};
        sq_trial = {2'b00, root, 2'b01};
        sq_fit = sq_shift >= sq_trial;
        sq_diff = sq_fit ? sq_shift - sq_trial : sq_shift;
    end

    // Restoring division, quotient bits shift in behind the numerator
    always_comb begin
        div_shift = {div_rem, quot[inv_width-1]};
        div_fit = div_shift >= {1'b0, root};
        div_diff = div_fit ? div_shift - {1'b0, root} : div_shift;
        quot_next = {quot[inv_width-2:0], div_fit};
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= s_idle;
            step <= '0;
            inv_valid <= 1'b0;
        end else begin
            case (state)
                s_idle: begin
                    if (inv_valid && inv_ready) begin
                        inv_valid <= 1'b0;
                    end
                    if (mean_valid && mean_ready) begin
                        state <= s_sqrt;
                        step <= step_width'(root_width - 1);
                    end
                end
                s_sqrt: begin
                    if (step == '0) begin
                        state <= s_div;
                        step <= step_width'(inv_width - 1);
                    end else begin
                        step <= step - 1'b1;
                    end
                end
                s_div: begin
                    if (step == '0) begin
                        state <= s_idle;
                        inv_valid <= 1'b1;
                    end else begin
                        step <= step - 1'b1;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            s_idle: begin
                if (mean_valid && mean_ready) begin
                    rad <= (2 * root_width)'(mean_data);
                    sq_rem <= '0;
                    root <= '0;
                    div_rem <= '0;
                    quot <= numerator;
                end
            end
            s_sqrt: begin
                rad <= rad << 2;
                sq_rem <= sq_diff[rem_width-1:0];
                root <= {root[root_width-2:0], sq_fit};
            end
            s_div: begin
                div_rem <= div_diff[root_width-1:0];
                quot <= quot_next;
                // Zero root saturates to the largest scale
                if (step == '0) begin
                    inv_data <= (root == '0) ? '1 : quot_next;
                end
            end
            default: ;
        endcase
    end
endmodule

`default_nettype wire

// File: hw/matrix_fifo.sv
// Lane-vector FIFO that keeps input beats until the scale factor of their group is ready
`timescale 1ns/100ps
`default_nettype none

module matrix_fifo #(
    parameter int total_dim0 = 4,
    parameter int total_dim1 = 4,
    parameter int compute_dim0 = 2,
    parameter int compute_dim1 = 2,
    parameter int channels = 2,
    localparam int lanes = compute_dim0 * compute_dim1,
    localparam int num_iters = (total_dim0 / compute_dim0) * (total_dim1 / compute_dim1)
        * channels
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [rms_norm_pkg::in_width-1:0] in_data [lanes-1:0],
    input  logic                              in_valid,
    output logic                              in_ready,
    output logic [rms_norm_pkg::in_width-1:0] out_data [lanes-1:0],
    output logic                              out_valid,
    input  logic                              out_ready
);
    // Room for two whole groups
    localparam int depth = 2 * num_iters;
    localparam int ptr_width = $clog2(depth);
    localparam int count_width = $clog2(depth + 1);

    logic [rms_norm_pkg::in_width-1:0] mem [depth-1:0][lanes-1:0];
    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [count_width-1:0] count;
    logic push;
    logic pop;

    assign in_ready = count != count_width'(depth);
    assign out_valid = count != '0;
    assign push = in_valid && in_ready;
    assign pop = out_valid && out_ready;
    assign out_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end
endmodule

`default_nettype wire

// File: hw/norm_scale.sv
// Joins beats with their scale factor, multiplies, then floors and saturates to the output format
`timescale 1ns/100ps
`default_nettype none

module norm_scale #(
    parameter int compute_dim0 = 2,
    parameter int compute_dim1 = 2,
    localparam int lanes = compute_dim0 * compute_dim1
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [rms_norm_pkg::in_width-1:0]       beat_data [lanes-1:0],
    input  logic                                    beat_valid,
    output logic                                    beat_ready,
    input  logic [rms_norm_pkg::inv_sqrt_width-1:0] scale_data,
    input  logic                                    scale_valid,
    output logic                                    scale_ready,
    output logic [rms_norm_pkg::out_width-1:0]      out_data [lanes-1:0],
    output logic                                    out_valid,
    input  logic                                    out_ready
);
    localparam int prod_width = rms_norm_pkg::inv_sqrt_width + rms_norm_pkg::in_width;
    localparam int norm_shift = rms_norm_pkg::in_frac_width
        + rms_norm_pkg::inv_sqrt_frac_width - rms_norm_pkg::out_frac_width;
    localparam logic signed [prod_width-1:0] out_max = (1 <<< (rms_norm_pkg::out_width - 1)) - 1;
    localparam logic signed [prod_width-1:0] out_min = -(1 <<< (rms_norm_pkg::out_width - 1));

    logic advance;
    logic prod_valid;
    logic signed [prod_width-1:0] prod [lanes-1:0];
    logic signed [prod_width-1:0] shifted [lanes-1:0];
    logic [rms_norm_pkg::out_width-1:0] cast [lanes-1:0];

    // Both stages move together unless the output is held
    assign advance = !out_valid || out_ready;
    assign beat_ready = advance && scale_valid;
    assign scale_ready = advance && beat_valid;

    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            shifted[i] = prod[i] >>> norm_shift;
            if (shifted[i] > out_max) begin
                cast[i] = out_max[rms_norm_pkg::out_width-1:0];
            end else if (shifted[i] < out_min) begin
                cast[i] = out_min[rms_norm_pkg::out_width-1:0];
            end else begin
                cast[i] = shifted[i][rms_norm_pkg::out_width-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
            out_valid <= 1'b0;
        end else if (advance) begin
            prod_valid <= beat_valid && scale_valid;
            out_valid <= prod_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            for (int i = 0; i < lanes; i++) begin
                // Scale is unsigned, so give it a zero sign bit
                prod[i] <= $signed({1'b0, scale_data}) * $signed(beat_data[i]);
                out_data[i] <= cast[i];
            end
        end
    end
endmodule

`default_nettype wire

// File: hw/repeat_buffer.sv
// Holds one scale factor and offers it once for every beat of its group
`timescale 1ns/100ps
`default_nettype none

module repeat_buffer #(
    parameter int total_dim0 = 4,
    parameter int total_dim1 = 4,
    parameter int compute_dim0 = 2,
    parameter int compute_dim1 = 2,
    parameter int channels = 2,
    localparam int num_iters = (total_dim0 / compute_dim0) * (total_dim1 / compute_dim1)
        * channels,
    localparam int count_width = $clog2(num_iters + 1)
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [rms_norm_pkg::inv_sqrt_width-1:0] in_data,
    input  logic                                    in_valid,
    output logic                                    in_ready,
    output logic [rms_norm_pkg::inv_sqrt_width-1:0] out_data,
    output logic                                    out_valid,
    input  logic                                    out_ready
);
    logic [count_width-1:0] count;

    assign in_ready = !out_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            count <= '0;
        end else if (in_valid && in_ready) begin
            out_valid <= 1'b1;
            count <= '0;
        end else if (out_valid && out_ready) begin
            // Free after the last beat of the group
            if (count == count_width'(num_iters - 1)) begin
                out_valid <= 1'b0;
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end
endmodule

`default_nettype wire

// File: hw/rms_norm_2d.sv
// RMS normalization top level; splits input beats between the FIFO and the scale path
`timescale 1ns/100ps
`default_nettype none

module rms_norm_2d #(
    parameter int total_dim0 = 4,
    parameter int total_dim1 = 4,
    parameter int compute_dim0 = 2,
    parameter int compute_dim1 = 2,
    parameter int channels = 2,
    localparam int lanes = compute_dim0 * compute_dim1,
    localparam int num_iters = (total_dim0 / compute_dim0) * (total_dim1 / compute_dim1)
        * channels
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [rms_norm_pkg::in_width-1:0]  in_data [lanes-1:0],
    input  logic                               in_valid,
    output logic                               in_ready,
    output logic [rms_norm_pkg::out_width-1:0] out_data [lanes-1:0],
    output logic                               out_valid,
    input  logic                               out_ready
);
    localparam int sum_width = rms_norm_pkg::square_width + $clog2(lanes);
    localparam int acc_width = sum_width + $clog2(num_iters);

    logic fifo_in_valid;
    logic fifo_in_ready;
    logic sq_in_valid;
    logic sq_in_ready;
    logic [rms_norm_pkg::in_width-1:0] fifo_data [lanes-1:0];
    logic fifo_valid;
    logic fifo_ready;
    logic [sum_width-1:0] sum_data;
    logic sum_valid;
    logic sum_ready;
    logic [acc_width-1:0] mean_data;
    logic mean_valid;
    logic mean_ready;
    logic [rms_norm_pkg::inv_sqrt_width-1:0] inv_data;
    logic inv_valid;
    logic inv_ready;
    logic [rms_norm_pkg::inv_sqrt_width-1:0] scale_data;
    logic scale_valid;
    logic scale_ready;

    // A beat enters both paths in the same cycle
    assign in_ready = fifo_in_ready && sq_in_ready;
    assign fifo_in_valid = in_valid && sq_in_ready;
    assign sq_in_valid = in_valid && fifo_in_ready;

    matrix_fifo #(
        .total_dim0(total_dim0), .total_dim1(total_dim1), .compute_dim0(compute_dim0),
        .compute_dim1(compute_dim1), .channels(channels)
    ) input_fifo (
        .clk(clk),
        .rst_n(rst_n),
        .in_data(in_data),
        .in_valid(fifo_in_valid),
        .in_ready(fifo_in_ready),
        .out_data(fifo_data),
        .out_valid(fifo_valid),
        .out_ready(fifo_ready)
    );

    square_reduce #(
        .compute_dim0(compute_dim0), .compute_dim1(compute_dim1)
    ) squares (
        .clk(clk),
        .rst_n(rst_n),
        .in_data(in_data),
        .in_valid(sq_in_valid),
        .in_ready(sq_in_ready),
        .sum_data(sum_data),
        .sum_valid(sum_valid),
        .sum_ready(sum_ready)
    );

    square_accumulator #(
        .total_dim0(total_dim0), .total_dim1(total_dim1), .compute_dim0(compute_dim0),
        .compute_dim1(compute_dim1), .channels(channels)
    ) mean_acc (
        .clk(clk),
        .rst_n(rst_n),
        .sum_data(sum_data),
        .sum_valid(sum_valid),
        .sum_ready(sum_ready),
        .mean_data(mean_data),
        .mean_valid(mean_valid),
        .mean_ready(mean_ready)
    );

    inv_sqrt_unit #(
        .total_dim0(total_dim0), .total_dim1(total_dim1), .compute_dim0(compute_dim0),
        .compute_dim1(compute_dim1), .channels(channels)
    ) inv_sqrt (
        .clk(clk),
        .rst_n(rst_n),
        .mean_data(mean_data),
        .mean_valid(mean_valid),
        .mean_ready(mean_ready),
        .inv_data(inv_data),
        .inv_valid(inv_valid),
        .inv_ready(inv_ready)
    );

    repeat_buffer #(
        .total_dim0(total_dim0), .total_dim1(total_dim1), .compute_dim0(compute_dim0),
        .compute_dim1(compute_dim1), .channels(channels)
    ) scale_repeat (
        .clk(clk),
        .rst_n(rst_n),
        .in_data(inv_data),
        .in_valid(inv_valid),
        .in_ready(inv_ready),
        .out_data(scale_data),
        .out_valid(scale_valid),
        .out_ready(scale_ready)
    );

    norm_scale #(
        .compute_dim0(compute_dim0), .compute_dim1(compute_dim1)
    ) scaler (
        .clk(clk),
        .rst_n(rst_n),
        .beat_data(fifo_data),
        .beat_valid(fifo_valid),
        .beat_ready(fifo_ready),
        .scale_data(scale_data),
        .scale_valid(scale_valid),
        .scale_ready(scale_ready),
        .out_data(out_data),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );
endmodule

`default_nettype wire

// File: hw/rms_norm_pkg.sv
// Fixed-point formats shared by the RMS norm datapath and its testbench model
`default_nettype none

package rms_norm_pkg;
    // Signed input values
    localparam int in_width = 8;
    localparam int in_frac_width = 2;

    // Signed normalized outputs
    localparam int out_width = 8;
    localparam int out_frac_width = 4;

    // Unsigned inverse root scale
    localparam int inv_sqrt_width = 16;
    localparam int inv_sqrt_frac_width = 10;

    localparam int square_width = 2 * in_width;
endpackage

`default_nettype wire

// File: hw/square_accumulator.sv
// Adds the beat sums of one group and presents their mean as the mean square
`timescale 1ns/100ps
`default_nettype none

module square_accumulator #(
    parameter int total_dim0 = 4,
    parameter int total_dim1 = 4,
    parameter int compute_dim0 = 2,
    parameter int compute_dim1 = 2,
    parameter int channels = 2,
    localparam int lanes = compute_dim0 * compute_dim1,
    localparam int num_iters = (total_dim0 / compute_dim0) * (total_dim1 / compute_dim1)
        * channels,
    localparam int sum_width = rms_norm_pkg::square_width + $clog2(lanes),
    localparam int acc_width = sum_width + $clog2(num_iters)
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [sum_width-1:0] sum_data,
    input  logic                 sum_valid,
    output logic                 sum_ready,
    output logic [acc_width-1:0] mean_data,
    output logic                 mean_valid,
    input  logic                 mean_ready
);
    localparam int num_values = lanes * num_iters;
    localparam int count_width = $clog2(num_iters + 1);

    logic [acc_width-1:0] total;
    logic [acc_width-1:0] total_next;
    logic [count_width-1:0] count;

    assign sum_ready = !mean_valid;
    assign total_next = total + acc_width'(sum_data);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            total <= '0;
            count <= '0;
            mean_valid <= 1'b0;
        end else if (sum_valid && sum_ready) begin
            if (count == count_width'(num_iters - 1)) begin
                // Group size is a power of two, so the mean is a shift
                mean_data <= total_next >> $clog2(num_values);
                mean_valid <= 1'b1;
                total <= '0;
                count <= '0;
            end else begin
                total <= total_next;
                count <= count + 1'b1;
            end
        end else if (mean_ready) begin
            mean_valid <= 1'b0;
        end
    end
endmodule

`default_nettype wire

// File: hw/square_reduce.sv
// Squares every lane of a beat and registers the sum of the lane squares
`timescale 1ns/100ps
`default_nettype none

module square_reduce #(
    parameter int compute_dim0 = 2,
    parameter int compute_dim1 = 2,
    localparam int lanes = compute_dim0 * compute_dim1,
    localparam int sum_width = rms_norm_pkg::square_width + $clog2(lanes)
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [rms_norm_pkg::in_width-1:0] in_data [lanes-1:0],
    input  logic                              in_valid,
    output logic                              in_ready,
    output logic [sum_width-1:0]              sum_data,
    output logic                              sum_valid,
    input  logic                              sum_ready
);
    logic [rms_norm_pkg::square_width-1:0] squares [lanes-1:0];
    logic [sum_width-1:0] lane_sum;

    // Squares are never negative
    for (genvar i = 0; i < lanes; i++) begin : gen_square
        assign squares[i] = $signed(in_data[i]) * $signed(in_data[i]);
    end

    always_comb begin
        lane_sum = '0;
        for (int i = 0; i < lanes; i++) begin
            lane_sum = lane_sum + sum_width'(squares[i]);
        end
    end

    // Single output slot, refilled in the cycle it drains
    assign in_ready = !sum_valid || sum_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            sum_valid <= 1'b1;
        end else if (sum_ready) begin
            sum_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            sum_data <= lane_sum;
        end
    end
endmodule

`default_nettype wire

// File: verification/rms_norm_2d_tb.sv
// Table-driven testbench for rms_norm_2d; compares every output lane with a fixed-point model
`timescale 1ns/100ps
`default_nettype none

module rms_norm_2d_tb;
    localparam int lanes = 4;
    localparam int num_iters = 8;
    localparam int num_values = lanes * num_iters;
    localparam int no_check = 1000;
    localparam int k_const = 0;
    localparam int k_ramp = 1;
    localparam int k_zero = 2;
    localparam int k_spike = 3;
    localparam int k_extreme = 4;
    localparam int k_random = 5;
    localparam int in_max = (1 << (rms_norm_pkg::in_width - 1)) - 1;
    localparam int in_min = -(1 << (rms_norm_pkg::in_width - 1));
    localparam int out_max = (1 << (rms_norm_pkg::out_width - 1)) - 1;
    localparam int out_min = -(1 << (rms_norm_pkg::out_width - 1));
    localparam int scale_max = (1 << rms_norm_pkg::inv_sqrt_width) - 1;
    localparam int out_shift = rms_norm_pkg::in_frac_width
        + rms_norm_pkg::inv_sqrt_frac_width - rms_norm_pkg::out_frac_width;

    logic clk;
    logic rst_n;
    logic [rms_norm_pkg::in_width-1:0] in_data [lanes-1:0];
    logic in_valid;
    logic in_ready;
    logic [rms_norm_pkg::out_width-1:0] out_data [lanes-1:0];
    logic out_valid;
    logic out_ready;
    logic bp_active = 1'b0;

    int row_kind [$];
    int row_base [$];
    int row_bp [$];
    int row_gap [$];
    int row_first [$];
    int exp_q [$];
    int in_beats = 0;
    int out_beats = 0;
    int checks = 0;
    int errors = 0;
    int row_errors = 0;
    int cycle_limit = 0;
    int cycle_count = 0;

    rms_norm_2d #(
        .total_dim0(4), .total_dim1(4), .compute_dim0(2), .compute_dim1(2), .channels(2)
    ) uut (
        .clk(clk),
        .rst_n(rst_n),
        .in_data(in_data),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_data(out_data),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

    function automatic int int_sqrt(input int x);
        int r;
        r = 0;
        while ((r + 1) * (r + 1) <= x) begin
            r++;
        end
        return r;
    endfunction

    // Zero root gives the largest scale
    function automatic int scale_for_root(input int root);
        int q;
        if (root == 0) begin
            return scale_max;
        end
        q = (1 << (rms_norm_pkg::inv_sqrt_frac_width + rms_norm_pkg::in_frac_width)) / root;
        return (q > scale_max) ? scale_max : q;
    endfunction

    function automatic int scaled_output(input int value, input int scale);
        int shifted;
        shifted = (value * scale) >>> out_shift;
        if (shifted > out_max) begin
            return out_max;
        end else if (shifted < out_min) begin
            return out_min;
        end
        return shifted;
    endfunction

    function automatic int pattern_value(input int kind, input int base, input int idx);
        case (kind)
            k_const: return base;
            k_ramp: return base + idx;
            k_spike: return (idx == 0) ? base : 0;
            k_extreme: return (idx % 2 == 0) ? in_max : in_min;
            k_random: return int'($urandom_range(255)) - 128;
            default: return 0;
        endcase
    endfunction

    function automatic string kind_name(input int kind);
        case (kind)
            k_const: return "constant";
            k_ramp: return "ramp";
            k_zero: return "zero";
            k_spike: return "spike";
            k_extreme: return "extremes";
            default: return "random";
        endcase
    endfunction

    task automatic add_row(input int kind, input int base, input int bp, input int gap,
        input int first);
        row_kind.push_back(kind);
        row_base.push_back(base);
        row_bp.push_back(bp);
        row_gap.push_back(gap);
        row_first.push_back(first);
    endtask

    task automatic report_mismatch(input string name, input int expected,
        input logic signed [31:0] actual);
        $display("[ERROR] time %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        errors++;
        row_errors++;
    endtask

    task automatic report_failure(input string what);
        $display("%s (time %0t)", what, $time);
        errors++;
    endtask

    task automatic check_idle();
        assert (out_valid === 1'b0)
        else report_mismatch("out_valid", 0, {31'b0, out_valid});
        assert (in_ready === 1'b1)
        else report_mismatch("in_ready", 1, {31'b0, in_ready});
    endtask

    task automatic send_row(input int r);
        int vals [num_values];
        int sum_sq;
        int scale;
        int gap;
        sum_sq = 0;
        for (int i = 0; i < num_values; i++) begin
            vals[i] = pattern_value(row_kind[r], row_base[r], i);
            sum_sq += vals[i] * vals[i];
        end
        scale = scale_for_root(int_sqrt(sum_sq >> $clog2(num_values)));
        for (int i = 0; i < num_values; i++) begin
            exp_q.push_back(scaled_output(vals[i], scale));
        end
        bp_active = row_bp[r] != 0;
        for (int b = 0; b < num_iters; b++) begin
            for (int l = 0; l < lanes; l++) begin
                in_data[l] = vals[b * lanes + l][rms_norm_pkg::in_width-1:0];
            end
            in_valid = 1'b1;
            @(posedge clk);
            while (!in_ready) begin
                @(posedge clk);
            end
            #1;
            in_beats++;
            if (row_gap[r] != 0) begin
                gap = $urandom_range(2);
                in_valid = 1'b0;
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                end
            end
        end
    endtask

    task automatic check_output_beat();
        int expected;
        int row;
        row = out_beats / num_iters;
        assert (exp_q.size() >= lanes)
        else begin
            report_failure("An output beat arrived that no input beat accounts for");
            return;
        end
        // First beat of a row also checked against the table
        if (out_beats % num_iters == 0 && row_first[row] != no_check) begin
            checks++;
            assert ($signed(out_data[0]) == row_first[row])
            else report_mismatch("out_data[0]", row_first[row], $signed(out_data[0]));
        end
        for (int l = 0; l < lanes; l++) begin
            expected = exp_q.pop_front();
            checks++;
            assert ($signed(out_data[l]) == expected)
            else report_mismatch($sformatf("out_data[%0d]", l), expected, $signed(out_data[l]));
        end
        out_beats++;
        if (out_beats % num_iters == 0) begin
            $display("Row %0d (%s): %0d beats checked, %0d errors", row,
                kind_name(row_kind[row]), num_iters, row_errors);
            row_errors = 0;
        end
    endtask

    always @(posedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            check_output_beat();
        end
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Random output stalls on back-pressure rows
    initial begin
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            out_ready = bp_active ? ($urandom_range(3) != 0) : 1'b1;
        end
    end

    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the DUT did not return all output beats within %0d cycles",
            cycle_limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(83107));
        rst_n = 1'b0;
        in_valid = 1'b0;
        for (int l = 0; l < lanes; l++) begin
            in_data[l] = '0;
        end
        // kind, base, back-pressure, gaps, expected first output of lane 0
        add_row(k_const, 4, 0, 0, 16);
        add_row(k_const, -6, 0, 1, -16);
        add_row(k_ramp, -16, 0, 0, -29);
        add_row(k_zero, 0, 1, 0, 0);
        add_row(k_spike, 3, 0, 1, 127);
        add_row(k_spike, -2, 1, 0, -128);
        add_row(k_extreme, 0, 0, 0, 15);
        add_row(k_random, 0, 1, 1, no_check);
        add_row(k_random, 0, 1, 0, no_check);
        add_row(k_const, 100, 0, 0, 15);
        add_row(k_ramp, 90, 1, 0, 13);
        add_row(k_random, 0, 0, 0, no_check);
        add_row(k_const, -128, 1, 0, -16);
        cycle_limit = row_kind.size() * (num_iters + 40 + 20) * 4;

        for (int c = 0; c < 10; c++) begin
            @(posedge clk);
            if (c > 0) begin
                check_idle();
            end
        end
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        check_idle();
        #1;

        for (int r = 0; r < row_kind.size(); r++) begin
            send_row(r);
        end
        in_valid = 1'b0;
        wait (out_beats >= row_kind.size() * num_iters);
        repeat (10) @(posedge clk);

        assert (out_beats == in_beats)
        else report_failure("Output beat count differs from input beat count");
        $display("Done: %0d rows, %0d beats in, %0d beats out, %0d checks, %0d errors",
            row_kind.size(), in_beats, out_beats, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end
endmodule

`default_nettype wire
